// File: filelist.f
source/sched_cfg_pkg.sv
source/sched_types_pkg.sv
source/sched_if.sv
source/bank_state_decode.sv
source/cmd_arbiter.sv
source/cmd_issue.sv
source/cmd_scheduler.sv
sim/cmd_scheduler_assert.sv
sim/tb_cmd_scheduler.sv

// File: Makefile
# Verilator build and run for the DRAM command scheduler

VERILATOR  = verilator
TOP        = tb_cmd_scheduler
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
RUN_ARGS   = +verilator+error+limit+1000
FAIL_MSG   = SOME TESTS FAILED
PASS_MSG   = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/sched_cases.txt
# test cycles state0 state1 state2 state3 addr0 addr1 addr2 addr3 fifo_full
# then expected issue cmd addr bank stall[3:0], addr ffff and bank f are not checked
1  2 0 0 0 0 01a0 02b1 03c2 04d3 0 0 0 ffff f 1111
2  1 0 0 5 0 01a0 02b1 03c2 04d3 0 1 2 03c2 2 1011
2  2 0 5 5 0 01a0 02b1 03c2 04d3 0 1 2 03c2 2 1011
2  1 0 0 0 0 01a0 02b1 03c2 04d3 0 0 0 ffff f 1111
2  2 0 5 0 5 01a0 02b1 03c2 04d3 0 1 2 02b1 1 1101
3  2 0 5 0 5 01a0 02b1 03c2 04d3 1 0 0 02b1 1 1111
3  1 0 5 0 5 01a0 02b1 03c2 04d3 0 1 2 02b1 1 1101
4  1 0 0 0 0 01a0 02b1 03c2 04d3 0 0 0 ffff f 1111
4  1 7 5 3 0 01a0 02b1 03c2 04d3 0 1 1 03c2 2 1011
4 17 7 5 3 9 01a0 02b1 03c2 04d3 0 1 1 03c2 2 1011
4  1 7 5 3 9 01a0 02b1 03c2 04d3 0 1 4 04d3 3 0111
5  1 0 0 0 0 01a0 02b1 03c2 04d3 0 0 0 ffff f 1111
5  1 7 0 0 0 01a0 02b1 03c2 04d3 0 1 3 01a0 0 1110
5  2 7 5 0 0 01a0 02b1 03c2 04d3 0 1 3 01a0 0 1110
5  1 0 5 0 0 01a0 02b1 03c2 04d3 0 1 2 02b1 1 1101
5  2 7 5 0 0 01a0 02b1 03c2 04d3 0 1 2 02b1 1 1101
6  1 0 6 0 0 01a0 02b1 03c2 04d3 0 0 0 02b1 1 1101
6  1 5 0 0 2 01a0 02b1 03c2 04d3 0 0 0 04d3 3 0111

// File: sim/tb_cmd_scheduler.sv
/*
  Testbench for the DRAM command scheduler
  Reads the case table, drives bank states each cycle,
  checks issue, cmd, addr, bank and stall, reports counts
*/

`timescale 1ns/1ns

module tb_cmd_scheduler;

  localparam int NB           = sched_cfg_pkg::NUM_BANKS;
  localparam int ADDR_BITS    = sched_cfg_pkg::ADDR_BITS;
  localparam int BANK_BITS    = sched_cfg_pkg::BANK_BITS;
  localparam int MAX_LINES    = 64;
  localparam int RESET_CYCLES = 3;

  logic                         clk;
  logic                         rst_n;
  sched_types_pkg::bank_state_t bank_state [NB];
  logic [ADDR_BITS-1:0]         bank_addr  [NB];
  logic                         fifo_full;
  logic                         issue;
  sched_types_pkg::dram_cmd_t   cmd;
  logic [ADDR_BITS-1:0]         addr;
  logic [BANK_BITS-1:0]         bank;
  logic [NB-1:0]                stall;

  // Columns 0 test, 1 cycles, 2..5 states, 6..9 addresses, 10 fifo_full,
  // 11 issue, 12 cmd, 13 addr, 14 bank, 15 stall
  int tbl [MAX_LINES][16];
  int num_lines    = 0;
  int total_cycles = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;
  int errors       = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  cmd_scheduler #(
    .ADDR_BITS     (ADDR_BITS),
    .AGE_WIDTH     (sched_cfg_pkg::AGE_WIDTH),
    .PRE_AGE_LIMIT (sched_cfg_pkg::PRE_AGE_LIMIT)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .bank_state (bank_state),
    .bank_addr  (bank_addr),
    .fifo_full  (fifo_full),
    .issue      (issue),
    .cmd        (cmd),
    .addr       (addr),
    .bank       (bank),
    .stall      (stall)
  );

  always #2 clk = ~clk;   // 4 ns period

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout, the run went past %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Case table
  //////////////////////////////

  task automatic load_cases();
    int    fd;
    int    cnt;
    int    v [16];
    string line;
    fd = $fopen("sim/sched_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file sim/sched_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && num_lines < MAX_LINES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %b",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                      v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
        if (cnt != 16) begin
          $display("Case line could not be read: %s", line);
          errors++;
        end else begin
          tbl[num_lines] = v;
          total_cycles += v[1];
          num_lines++;
        end
      end
    end
    $fclose(fd);
    if (num_lines == 0) begin
      $display("The case file holds no case lines");
      errors++;
    end
  endtask

  task automatic apply_inputs(input int k);
    for (int i = 0; i < NB; i++) begin
      bank_state[i] = sched_types_pkg::bank_state_t'(tbl[k][2+i][3:0]);
      bank_addr[i]  = tbl[k][6+i][ADDR_BITS-1:0];
    end
    fifo_full = tbl[k][10][0];
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    errors++;
    test_errors++;
  endtask

  task automatic check_outputs(input int k);
    assert (issue === tbl[k][11][0])
      else report_mismatch("issue", tbl[k][11], 32'(issue));
    assert (cmd === tbl[k][12][2:0])
      else report_mismatch("cmd", tbl[k][12], 32'(cmd));
    if (tbl[k][13] != 'hffff) begin
      assert (addr === tbl[k][13][ADDR_BITS-1:0])
        else report_mismatch("addr", tbl[k][13], 32'(addr));
    end
    if (tbl[k][14] != 'hf) begin
      assert (bank === tbl[k][14][BANK_BITS-1:0])
        else report_mismatch("bank", tbl[k][14], 32'(bank));
    end
    assert (stall === tbl[k][15][NB-1:0])
      else report_mismatch("stall", tbl[k][15], 32'(stall));
  endtask

  task automatic finish_test(input int t);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d passed", t);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d mismatches", t, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    fifo_full = 1'b0;
    for (int i = 0; i < NB; i++) begin
      bank_state[i] = sched_types_pkg::B_IDLE;
      bank_addr[i]  = '0;
    end
    load_cases();
    cycle_limit = total_cycles + RESET_CYCLES + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int k = 0; k < num_lines; k++) begin
      for (int c = 0; c < tbl[k][1]; c++) begin
        apply_inputs(k);
        #2;                                     // Outputs settled, edge still ahead
        check_outputs(k);
        @(posedge clk);
        #1;
      end
      if (k == num_lines - 1 || tbl[k+1][0] != tbl[k][0])
        finish_test(tbl[k][0]);
    end
    errors += DUT.u_assert.assert_failures;
    $display("Tests run %0d, failed %0d, errors %0d, concurrent assertion failures %0d",
             tests_run, tests_failed, errors, DUT.u_assert.assert_failures);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/cmd_scheduler_assert.sv
/*
  Concurrent checks bound to the scheduler top level
  Stall mask, issue against FIFO full and the issued bank
*/

`timescale 1ns/1ns

module cmd_scheduler_assert (
  input logic                                clk,
  input logic                                rst_n,
  input logic                                fifo_full,
  input logic                                issue,
  input logic [sched_cfg_pkg::BANK_BITS-1:0] bank,
  input logic [sched_cfg_pkg::NUM_BANKS-1:0] stall
);

  int assert_failures = 0;   // Summed into the final count

  // Only one bank may advance per cycle
  a_one_release: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(~stall))
    else begin
      assert_failures++;
      $error("more than one bank released from stall");
    end

  a_issue_not_full: assert property (@(posedge clk) disable iff (!rst_n) issue |-> !fifo_full)
    else begin
      assert_failures++;
      $error("issue strobe while the FIFO is full");
    end

  a_issue_bank_free: assert property (@(posedge clk) disable iff (!rst_n) issue |-> !stall[bank])
    else begin
      assert_failures++;
      $error("issued bank is stalled");
    end

  // Back-pressure holds every bank
  a_full_stalls_all: assert property (@(posedge clk) disable iff (!rst_n) fifo_full |-> &stall)
    else begin
      assert_failures++;
      $error("a bank released while the FIFO is full");
    end

endmodule

bind cmd_scheduler cmd_scheduler_assert u_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .fifo_full (fifo_full),
  .issue     (issue),
  .bank      (bank),
  .stall     (stall)
);

// File: source/cmd_scheduler.sv
/*
  DRAM command scheduler top level
  Bank state decode, arbiter and issue stage
*/

`timescale 1ns/1ns

module cmd_scheduler #(
  parameter int ADDR_BITS     = sched_cfg_pkg::ADDR_BITS,
  parameter int AGE_WIDTH     = sched_cfg_pkg::AGE_WIDTH,
  parameter int PRE_AGE_LIMIT = sched_cfg_pkg::PRE_AGE_LIMIT
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  sched_types_pkg::bank_state_t        bank_state [sched_cfg_pkg::NUM_BANKS],
  input  logic [ADDR_BITS-1:0]                bank_addr  [sched_cfg_pkg::NUM_BANKS],
  input  logic                                fifo_full,
  output logic                                issue,
  output sched_types_pkg::dram_cmd_t          cmd,
  output logic [ADDR_BITS-1:0]                addr,
  output logic [sched_cfg_pkg::BANK_BITS-1:0] bank,
  output logic [sched_cfg_pkg::NUM_BANKS-1:0] stall
);

  bank_req_if #(.AGE_WIDTH(AGE_WIDTH)) req ();
  grant_if                             gnt ();

  bank_state_decode #(.AGE_WIDTH(AGE_WIDTH)) u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .bank_state (bank_state),
    .req        (req.decode)
  );

  cmd_arbiter #(
    .AGE_WIDTH     (AGE_WIDTH),
    .PRE_AGE_LIMIT (PRE_AGE_LIMIT)
  ) u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .fifo_full (fifo_full),
    .req       (req.arbiter),
    .gnt       (gnt.arbiter)
  );

  cmd_issue #(.ADDR_BITS(ADDR_BITS)) u_issue (
    .gnt       (gnt.issue),
    .bank_addr (bank_addr),
    .fifo_full (fifo_full),
    .issue     (issue),
    .cmd       (cmd),
    .addr      (addr),
    .bank      (bank),
    .stall     (stall)
  );

endmodule

// File: source/cmd_issue.sv
/*
  Command issue
  Opcode, address and bank of the granted bank,
  issue strobe and per-bank stall mask
*/

`timescale 1ns/1ns

module cmd_issue #(
  parameter int ADDR_BITS = sched_cfg_pkg::ADDR_BITS
) (
  grant_if.issue                              gnt,
  input  logic [ADDR_BITS-1:0]                bank_addr [sched_cfg_pkg::NUM_BANKS],
  input  logic                                fifo_full,
  output logic                                issue,
  output sched_types_pkg::dram_cmd_t          cmd,
  output logic [ADDR_BITS-1:0]                addr,
  output logic [sched_cfg_pkg::BANK_BITS-1:0] bank,
  output logic [sched_cfg_pkg::NUM_BANKS-1:0] stall
);

  assign issue = gnt.grant_valid && gnt.grant_ready && !fifo_full;

  always_comb begin
    cmd = sched_types_pkg::CMD_NOP;
    if (issue) begin
      case (gnt.grant_class)
        sched_types_pkg::CLS_ACT: cmd = sched_types_pkg::CMD_ACTIVE;
        sched_types_pkg::CLS_WR:  cmd = sched_types_pkg::CMD_WRITE;
        sched_types_pkg::CLS_RD:  cmd = sched_types_pkg::CMD_READ;
        sched_types_pkg::CLS_PRE: cmd = sched_types_pkg::CMD_PRECHARGE;
        default:                  cmd = sched_types_pkg::CMD_NOP;
      endcase
    end
  end

  assign addr = bank_addr[gnt.grant_bank];
  assign bank = gnt.grant_bank;

  // Only the granted bank may advance, none while the FIFO is full
  always_comb begin
    stall = '1;
    if (gnt.grant_valid && !fifo_full)
      stall[gnt.grant_bank] = 1'b0;
  end

endmodule

// File: source/cmd_arbiter.sv
/*
  Command arbiter
  Class priority with precharge age limit, read/write
  direction memory and oldest-bank grant within a class
*/

`timescale 1ns/1ns

module cmd_arbiter #(
  parameter int AGE_WIDTH     = sched_cfg_pkg::AGE_WIDTH,
  parameter int PRE_AGE_LIMIT = sched_cfg_pkg::PRE_AGE_LIMIT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fifo_full,
  bank_req_if.arbiter req,
  grant_if.arbiter    gnt
);

  localparam int NB = sched_cfg_pkg::NUM_BANKS;
  localparam int BB = sched_cfg_pkg::BANK_BITS;

  logic [AGE_WIDTH-1:0]        age [NB];
  logic [BB-1:0]               oldest_any;
  logic                        oldest_is_pre;
  logic                        pre_due;
  logic                        dir_read;      // 0 write, 1 read
  sched_types_pkg::cmd_class_t sel_class;
  logic [NB-1:0]               class_mask;
  logic [BB-1:0]               sel_bank;

  assign age = req.age;

  // Highest age among masked banks, lowest index on a tie
  function automatic logic [BB-1:0] pick_oldest(input logic [NB-1:0] mask);
    logic [BB-1:0]        best;
    logic [AGE_WIDTH-1:0] best_age;
    logic                 found;
    best     = '0;
    best_age = '0;
    found    = 1'b0;
    for (int i = 0; i < NB; i++) begin
      if (mask[i] && (!found || age[i] > best_age)) begin
        best     = i[BB-1:0];
        best_age = age[i];
        found    = 1'b1;
      end
    end
    return best;
  endfunction

  //////////////////////////////
  // Class priority
  //////////////////////////////

  always_comb begin
    oldest_any    = pick_oldest(req.waiting);
    oldest_is_pre = (req.class_of[oldest_any] == sched_types_pkg::CLS_PRE);
  end

  always_comb begin
    pre_due = 1'b0;
    for (int i = 0; i < NB; i++) begin
      if (req.waiting[i] && req.class_of[i] == sched_types_pkg::CLS_PRE &&
          age[i] > PRE_AGE_LIMIT)
        pre_due = 1'b1;
    end
  end

  always_comb begin
    if (req.pend[sched_types_pkg::CLS_PRE] && (oldest_is_pre || pre_due))
      sel_class = sched_types_pkg::CLS_PRE;
    else if (req.pend[sched_types_pkg::CLS_ACT])
      sel_class = sched_types_pkg::CLS_ACT;
    else if (req.pend[sched_types_pkg::CLS_WR] && req.pend[sched_types_pkg::CLS_RD])
      sel_class = dir_read ? sched_types_pkg::CLS_RD : sched_types_pkg::CLS_WR;
    else if (req.pend[sched_types_pkg::CLS_WR])
      sel_class = sched_types_pkg::CLS_WR;
    else if (req.pend[sched_types_pkg::CLS_RD])
      sel_class = sched_types_pkg::CLS_RD;
    else
      sel_class = sched_types_pkg::CLS_PRE;   // Precharge not yet due, or nothing at all
  end

  //////////////////////////////
  // Oldest bank of the class
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NB; i++)
      class_mask[i] = req.waiting[i] && (req.class_of[i] == sel_class);
  end

  always_comb begin
    sel_bank = pick_oldest(class_mask);
  end

  assign gnt.grant_valid = !req.nothing_pending;
  assign gnt.grant_class = sel_class;
  assign gnt.grant_bank  = sel_bank;
  assign gnt.grant_ready = req.ready[sel_bank];

  // Direction follows the last issued read or write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dir_read <= 1'b0;
    end else if (!req.nothing_pending && req.ready[sel_bank] && !fifo_full) begin
      if (sel_class == sched_types_pkg::CLS_RD)
        dir_read <= 1'b1;
      else if (sel_class == sched_types_pkg::CLS_WR)
        dir_read <= 1'b0;
    end
  end

endmodule

// File: source/bank_state_decode.sv
/*
  Bank state decode
  One saturating age counter per bank, the class each bank
  waits for, its ready flag and the pending class mask
*/

`timescale 1ns/1ns

module bank_state_decode #(
  parameter int AGE_WIDTH = sched_cfg_pkg::AGE_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  sched_types_pkg::bank_state_t  bank_state [sched_cfg_pkg::NUM_BANKS],
  bank_req_if.decode                    req
);

  localparam int NB = sched_cfg_pkg::NUM_BANKS;

  logic [AGE_WIDTH-1:0]        age_q [NB];
  sched_types_pkg::cmd_class_t class_d [NB];
  logic [NB-1:0]               waiting_d;
  logic [NB-1:0]               ready_d;
  logic [3:0]                  pend_d;

  //////////////////////////////
  // State to class decode
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      class_d[i]   = sched_types_pkg::CLS_ACT;
      waiting_d[i] = 1'b1;
      ready_d[i]   = 1'b0;
      case (bank_state[i])
        sched_types_pkg::B_ACT_CHECK:   class_d[i] = sched_types_pkg::CLS_ACT;
        sched_types_pkg::B_ACTIVE: begin
          class_d[i] = sched_types_pkg::CLS_ACT;
          ready_d[i] = 1'b1;
        end
        sched_types_pkg::B_WRITE_CHECK: class_d[i] = sched_types_pkg::CLS_WR;
        sched_types_pkg::B_WRITE: begin
          class_d[i] = sched_types_pkg::CLS_WR;
          ready_d[i] = 1'b1;
        end
        sched_types_pkg::B_READ_CHECK:  class_d[i] = sched_types_pkg::CLS_RD;
        sched_types_pkg::B_READ: begin
          class_d[i] = sched_types_pkg::CLS_RD;
          ready_d[i] = 1'b1;
        end
        sched_types_pkg::B_PRE_CHECK:   class_d[i] = sched_types_pkg::CLS_PRE;
        sched_types_pkg::B_PRE: begin
          class_d[i] = sched_types_pkg::CLS_PRE;
          ready_d[i] = 1'b1;
        end
        default: waiting_d[i] = 1'b0;   // IDLE, ACT_STANDBY and unused codes
      endcase
    end
  end

  // OR of all waiting banks per class
  always_comb begin
    pend_d = '0;
    for (int i = 0; i < NB; i++) begin
      if (waiting_d[i]) pend_d[class_d[i]] = 1'b1;
    end
  end

  //////////////////////////////
  // Age counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NB; i++) age_q[i] <= '0;
    end else begin
      for (int i = 0; i < NB; i++) begin
        if (!waiting_d[i])
          age_q[i] <= '0;
        else if (age_q[i] != {AGE_WIDTH{1'b1}})
          age_q[i] <= age_q[i] + 1'b1;   // Hold at max
      end
    end
  end

  assign req.pend            = pend_d;
  assign req.age             = age_q;
  assign req.class_of        = class_d;
  assign req.waiting         = waiting_d;
  assign req.ready           = ready_d;
  assign req.nothing_pending = (pend_d == 4'b0000);

endmodule

// File: source/sched_if.sv
/*
  Internal scheduler interfaces
  bank_req_if  per-bank requests from the state decode
  grant_if     class and bank chosen by the arbiter
*/

`timescale 1ns/1ns

interface bank_req_if #(
  parameter int AGE_WIDTH = sched_cfg_pkg::AGE_WIDTH
);

  logic [3:0]                  pend;            // One bit per command class
  logic [AGE_WIDTH-1:0]        age      [sched_cfg_pkg::NUM_BANKS];
  sched_types_pkg::cmd_class_t class_of [sched_cfg_pkg::NUM_BANKS];
  logic [sched_cfg_pkg::NUM_BANKS-1:0] waiting; // Bank is in a check or ready state
  logic [sched_cfg_pkg::NUM_BANKS-1:0] ready;
  logic                        nothing_pending;

  modport decode (
    output pend, age, class_of, waiting, ready, nothing_pending
  );

  modport arbiter (
    input pend, age, class_of, waiting, ready, nothing_pending
  );

endinterface

interface grant_if;

  logic                                grant_valid;
  sched_types_pkg::cmd_class_t         grant_class;
  logic [sched_cfg_pkg::BANK_BITS-1:0] grant_bank;
  logic                                grant_ready; // Granted bank may issue now

  modport arbiter (
    output grant_valid, grant_class, grant_bank, grant_ready
  );

  modport issue (
    input grant_valid, grant_class, grant_bank, grant_ready
  );

endinterface

// File: source/sched_types_pkg.sv
/*
  Scheduler type package
  Bank engine states, DRAM opcodes and command classes
*/

package sched_types_pkg;

  // Check states wait on timing, the plain ones are ready to issue
  typedef enum logic [3:0] {
    B_IDLE        = 4'd0,
    B_ACT_STANDBY = 4'd1,
    B_ACT_CHECK   = 4'd2,
    B_ACTIVE      = 4'd3,
    B_WRITE_CHECK = 4'd4,
    B_WRITE       = 4'd5,
    B_READ_CHECK  = 4'd6,
    B_READ        = 4'd7,
    B_PRE_CHECK   = 4'd8,
    B_PRE         = 4'd9
  } bank_state_t;

  // Opcode written to the issue FIFO
  typedef enum logic [2:0] {
    CMD_NOP       = 3'd0,
    CMD_ACTIVE    = 3'd1,
    CMD_WRITE     = 3'd2,
    CMD_READ      = 3'd3,
    CMD_PRECHARGE = 3'd4
  } dram_cmd_t;

  // Also the bit position in the pending mask
  typedef enum logic [1:0] {
    CLS_ACT = 2'd0,
    CLS_WR  = 2'd1,
    CLS_RD  = 2'd2,
    CLS_PRE = 2'd3
  } cmd_class_t;

endpackage

// File: source/sched_cfg_pkg.sv
/*
  Scheduler configuration package
  Bank count, index and address widths, age counter width
  and the precharge age limit used as module defaults
*/

package sched_cfg_pkg;

  //////////////////////////////
  // Bank geometry
  //////////////////////////////

  parameter int NUM_BANKS = 4;           // Arbiter and issue assume four banks
  parameter int BANK_BITS = 2;
  parameter int ADDR_BITS = 14;          // Row or column address of one bank

  //////////////////////////////
  // Arbitration limits
  //////////////////////////////

  // Age counters saturate at all ones
  parameter int AGE_WIDTH = 8;

  // A waiting precharge older than this jumps ahead of other classes
  parameter int PRE_AGE_LIMIT = 16;

endpackage
